//--- Makefile
VERILATOR  ?= verilator
TOP        := rs_tb
FILELIST   := rs_top.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- reservation_station.sv
// Eight-entry reservation station with two-wide dispatch, CDB wakeup and per-class issue

`timescale 1ns/1ps

module reservation_station import rs_pkg::*; (
	input  logic                                clock,
	input  logic                                arst_n,
	input  logic                                enable,
	input  logic                                flush,
	input  logic [NUM_FU-1:0]                   fu_mask,
	// Dispatch slots
	input  logic [DISPATCH_W-1:0]               disp_valid,
	input  opcode_e [DISPATCH_W-1:0]            disp_opcode,
	input  logic [DISPATCH_W-1:0][TAG_W-1:0]    disp_src1_tag,
	input  logic [DISPATCH_W-1:0]               disp_src1_ready,
	input  logic [DISPATCH_W-1:0][TAG_W-1:0]    disp_src2_tag,
	input  logic [DISPATCH_W-1:0]               disp_src2_ready,
	input  logic [DISPATCH_W-1:0][TAG_W-1:0]    disp_dest_tag,
	output logic [DISPATCH_W-1:0]               disp_accept,
	// Result bus
	input  logic [CDB_W-1:0]                    cdb_valid,
	input  logic [CDB_W-1:0][TAG_W-1:0]         cdb_tag,
	// Issue ports, indexed by unit class
	output logic [NUM_FU-1:0]                   issue_valid,
	output opcode_e [NUM_FU-1:0]                issue_opcode,
	output logic [NUM_FU-1:0][TAG_W-1:0]        issue_dest_tag,
	output logic [NUM_FU-1:0][TAG_W-1:0]        issue_src1_tag,
	output logic [NUM_FU-1:0][TAG_W-1:0]        issue_src2_tag,
	input  logic [NUM_FU-1:0]                   issue_stall,
	output logic [OCC_W-1:0]                    occupancy,
	output logic [ISSUE_CNT_W-1:0]              issue_count
);

	// Row table
	logic [RS_ENTRIES-1:0]                  busy;
	opcode_e                                ent_opcode [RS_ENTRIES];
	fu_class_e                              ent_class [RS_ENTRIES];
	logic [RS_ENTRIES-1:0][TAG_W-1:0]       ent_dest;
	logic [RS_ENTRIES-1:0][1:0][TAG_W-1:0]  ent_src_tag;
	logic [RS_ENTRIES-1:0][1:0]             ent_src_rdy;

	logic [RS_ENTRIES-1:0][1:0]             src_hit;
	logic [RS_ENTRIES-1:0][1:0]             src_ok;
	logic [NUM_FU-1:0][RS_ENTRIES-1:0]      issue_req;
	logic [NUM_FU-1:0][RS_IDX_W-1:0]        issue_idx;
	logic [NUM_FU-1:0]                      issue_found;
	logic [DISPATCH_W-1:0][RS_IDX_W-1:0]    alloc_idx;
	logic [DISPATCH_W-1:0]                  alloc_valid;
	logic [RS_ENTRIES-1:0]                  alloc1_req;
	logic [DISPATCH_W-1:0]                  disp_take;
	logic [DISPATCH_W-1:0][1:0]             disp_rdy;
	logic [RS_ENTRIES-1:0]                  issue_clr;
	logic [RS_ENTRIES-1:0]                  busy_next;
	logic [OCC_W-1:0]                       occ_next;

	////////////////////////////////////////////////////////////
	// Wakeup
	////////////////////////////////////////////////////////////

	rs_wakeup_cam u_cam (
		.entry_src_tags(ent_src_tag),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.src_hit       (src_hit)
	);

	// A source is ready if already marked or hit this cycle
	assign src_ok = ent_src_rdy | src_hit;

	////////////////////////////////////////////////////////////
	// Issue select, one picker per class
	////////////////////////////////////////////////////////////

	for (genvar f = 0; f < NUM_FU; f++) begin : g_issue
		for (genvar i = 0; i < RS_ENTRIES; i++) begin : g_req
			assign issue_req[f][i] = busy[i] && (ent_class[i] == fu_class_e'(f)) &&
				src_ok[i][0] && src_ok[i][1];
		end

		rs_select #(.REQ_W(RS_ENTRIES)) u_issue_sel (
			.req        (issue_req[f]),
			.grant_idx  (issue_idx[f]),
			.grant_valid(issue_found[f])
		);

		// Stall and mask hold the row in place
		assign issue_valid[f] = enable && !issue_stall[f] && !fu_mask[f] && issue_found[f];
		assign issue_opcode[f] = ent_opcode[issue_idx[f]];
		assign issue_dest_tag[f] = ent_dest[issue_idx[f]];
		assign issue_src1_tag[f] = ent_src_tag[issue_idx[f]][0];
		assign issue_src2_tag[f] = ent_src_tag[issue_idx[f]][1];
	end

	always_comb begin
		issue_count = '0;
		for (int f = 0; f < NUM_FU; f++) begin
			issue_count += ISSUE_CNT_W'(issue_valid[f]);
		end
	end

	////////////////////////////////////////////////////////////
	// Dispatch allocation
	////////////////////////////////////////////////////////////

	rs_select #(.REQ_W(RS_ENTRIES)) u_alloc0 (
		.req        (~busy),
		.grant_idx  (alloc_idx[0]),
		.grant_valid(alloc_valid[0])
	);

	// Slot 1 sees the free rows minus slot 0's pick
	assign alloc1_req = ~busy & ~(RS_ENTRIES'(alloc_valid[0]) << alloc_idx[0]);

	rs_select #(.REQ_W(RS_ENTRIES)) u_alloc1 (
		.req        (alloc1_req),
		.grant_idx  (alloc_idx[1]),
		.grant_valid(alloc_valid[1])
	);

	assign disp_accept = {DISPATCH_W{enable}} & alloc_valid;
	assign disp_take = disp_valid & disp_accept;

	// Catch a producer broadcasting in the dispatch cycle
	always_comb begin
		for (int k = 0; k < DISPATCH_W; k++) begin
			disp_rdy[k][0] = disp_src1_ready[k];
			disp_rdy[k][1] = disp_src2_ready[k];
			for (int c = 0; c < CDB_W; c++) begin
				if (cdb_valid[c] && (cdb_tag[c] == disp_src1_tag[k])) begin
					disp_rdy[k][0] = 1'b1;
				end
				if (cdb_valid[c] && (cdb_tag[c] == disp_src2_tag[k])) begin
					disp_rdy[k][1] = 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Next busy vector and occupancy
	////////////////////////////////////////////////////////////

	always_comb begin
		issue_clr = '0;
		for (int f = 0; f < NUM_FU; f++) begin
			if (issue_valid[f]) begin
				issue_clr[issue_idx[f]] = 1'b1;
			end
		end
		busy_next = busy & ~issue_clr;
		for (int k = 0; k < DISPATCH_W; k++) begin
			if (disp_take[k]) begin
				busy_next[alloc_idx[k]] = 1'b1;
			end
		end
		occ_next = '0;
		for (int i = 0; i < RS_ENTRIES; i++) begin
			occ_next += OCC_W'(busy_next[i]);
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			busy <= '0;
			occupancy <= '0;
		end else if (flush) begin
			busy <= '0;
			occupancy <= '0;
		end else begin
			busy <= busy_next;
			occupancy <= occ_next;
		end
	end

	// Row payload, written on dispatch
	always_ff @(posedge clock) begin
		ent_src_rdy <= src_ok;
		for (int k = 0; k < DISPATCH_W; k++) begin
			if (disp_take[k]) begin
				ent_opcode[alloc_idx[k]] <= disp_opcode[k];
				ent_class[alloc_idx[k]] <= opcode_class(disp_opcode[k]);
				ent_dest[alloc_idx[k]] <= disp_dest_tag[k];
				ent_src_tag[alloc_idx[k]][0] <= disp_src1_tag[k];
				ent_src_tag[alloc_idx[k]][1] <= disp_src2_tag[k];
				ent_src_rdy[alloc_idx[k]] <= disp_rdy[k];
			end
		end
	end

endmodule

//--- rs_checker.sv
// Concurrent assertions on issue exclusivity, occupancy tracking, flush and enable gating

`timescale 1ns/1ps

module rs_checker import rs_pkg::*; (
	input logic                             clock,
	input logic                             arst_n,
	input logic                             enable,
	input logic                             flush,
	input logic [RS_ENTRIES-1:0]            busy,
	input logic [OCC_W-1:0]                 occupancy,
	input logic [DISPATCH_W-1:0]            disp_valid,
	input logic [DISPATCH_W-1:0]            disp_accept,
	input logic [NUM_FU-1:0]                issue_valid,
	input logic [NUM_FU-1:0][RS_IDX_W-1:0]  issue_idx
);

	// Two live ports pointing at one row
	logic same_row;
	// Rows entering and leaving this cycle
	int   n_take;
	int   n_issue;

	assign same_row = (issue_valid[0] && issue_valid[1] && (issue_idx[0] == issue_idx[1])) ||
		(issue_valid[0] && issue_valid[2] && (issue_idx[0] == issue_idx[2])) ||
		(issue_valid[1] && issue_valid[2] && (issue_idx[1] == issue_idx[2]));

	assign n_take = $countones(disp_valid & disp_accept);
	assign n_issue = $countones(issue_valid);

	a_row_once: assert property (@(posedge clock) disable iff (!arst_n) !same_row)
		else $error("Two issue ports selected the same row");

	a_occ_track: assert property (@(posedge clock) disable iff (!arst_n)
		!flush |=> (int'(occupancy) ==
			int'($past(occupancy)) + $past(n_take) - $past(n_issue)))
		else $error("Occupancy does not follow dispatches and issues");

	a_flush_empty: assert property (@(posedge clock) disable iff (!arst_n)
		$past(flush) |-> (busy == '0))
		else $error("Rows still busy after flush");

	// A disabled station neither takes nor frees rows
	a_enable_gate: assert property (@(posedge clock) disable iff (!arst_n)
		!enable && !flush |=> (busy == $past(busy)))
		else $error("Rows changed while disabled");

endmodule

bind reservation_station rs_checker u_checker (
	.clock      (clock),
	.arst_n     (arst_n),
	.enable     (enable),
	.flush      (flush),
	.busy       (busy),
	.occupancy  (occupancy),
	.disp_valid (disp_valid),
	.disp_accept(disp_accept),
	.issue_valid(issue_valid),
	.issue_idx  (issue_idx)
);

//--- rs_config_apb.sv
// APB register block with enable, flush pulse, issue masks, occupancy and issued counter

`timescale 1ns/1ps

module rs_config_apb import rs_pkg::*; (
	input  logic                   clock,
	input  logic                   arst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [3:0]             paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  logic [OCC_W-1:0]       occupancy,
	input  logic [ISSUE_CNT_W-1:0] issue_count,
	output logic                   enable,
	output logic                   flush,
	output logic [NUM_FU-1:0]      fu_mask
);

	logic                access;
	logic                wr_en;
	logic                addr_ok;
	logic [ISSUED_W-1:0] issued_cnt;

	////////////////////////////////////////////////////////////
	// Bus decode
	////////////////////////////////////////////////////////////

	// No wait states
	assign pready = 1'b1;
	assign access = psel && penable;
	assign wr_en = access && pwrite && addr_ok;

	always_comb begin
		case (apb_reg_e'(paddr))
			REG_CTRL,
			REG_MASK,
			REG_STATUS,
			REG_ISSUED: addr_ok = 1'b1;
			default: addr_ok = 1'b0;
		endcase
	end

	assign pslverr = access && !addr_ok;

	// Read mux
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (apb_reg_e'(paddr))
				REG_CTRL: prdata[0] = enable;
				REG_MASK: prdata[NUM_FU-1:0] = fu_mask;
				REG_STATUS: prdata[OCC_W-1:0] = occupancy;
				REG_ISSUED: prdata[ISSUED_W-1:0] = issued_cnt;
				default: prdata = '0;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			enable <= 1'b0;
			flush <= 1'b0;
			fu_mask <= '0;
		end else begin
			// Flush lasts one cycle
			flush <= wr_en && (apb_reg_e'(paddr) == REG_CTRL) && pwdata[1];
			if (wr_en && (apb_reg_e'(paddr) == REG_CTRL)) begin
				enable <= pwdata[0];
			end
			if (wr_en && (apb_reg_e'(paddr) == REG_MASK)) begin
				fu_mask <= pwdata[NUM_FU-1:0];
			end
		end
	end

	// Issued counter wraps, any write clears it
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			issued_cnt <= '0;
		end else if (wr_en && (apb_reg_e'(paddr) == REG_ISSUED)) begin
			issued_cnt <= '0;
		end else begin
			issued_cnt <= issued_cnt + ISSUED_W'(issue_count);
		end
	end

endmodule

//--- rs_pkg.sv
// Reservation station sizes, opcode and unit-class enums, APB register map, opcode decode

package rs_pkg;

	////////////////////////////////////////////////////////////
	// Table and datapath sizes
	////////////////////////////////////////////////////////////

	localparam int RS_ENTRIES = 8;
	localparam int RS_IDX_W = 3;
	localparam int DISPATCH_W = 2;
	localparam int CDB_W = 2;
	localparam int TAG_W = 6;
	localparam int NUM_FU = 3;

	// Occupancy counts 0..RS_ENTRIES inclusive
	localparam int OCC_W = 4;
	// Ports issuing in one cycle, 0..NUM_FU
	localparam int ISSUE_CNT_W = 2;
	localparam int ISSUED_W = 16;

	////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////

	// Unit class, doubles as the issue port number
	typedef enum logic [1:0] {
		FU_ALU = 2'd0,
		FU_MUL = 2'd1,
		FU_LSU = 2'd2
	} fu_class_e;

	typedef enum logic [3:0] {
		OP_ADD   = 4'd0,
		OP_SUB   = 4'd1,
		OP_AND   = 4'd2,
		OP_OR    = 4'd3,
		OP_MUL   = 4'd4,
		OP_LOAD  = 4'd5,
		OP_STORE = 4'd6
	} opcode_e;

	// APB byte addresses
	typedef enum logic [3:0] {
		REG_CTRL   = 4'h0,
		REG_MASK   = 4'h4,
		REG_STATUS = 4'h8,
		REG_ISSUED = 4'hC
	} apb_reg_e;

	// Which unit class executes an opcode
	function automatic fu_class_e opcode_class(input opcode_e op);
		case (op)
			OP_MUL: return FU_MUL;
			OP_LOAD,
			OP_STORE: return FU_LSU;
			default: return FU_ALU;
		endcase
	endfunction

endpackage

//--- rs_select.sv
// Fixed-priority picker returning the lowest set request as an index

`timescale 1ns/1ps

module rs_select import rs_pkg::*; #(
	parameter int REQ_W = RS_ENTRIES
) (
	input  logic [REQ_W-1:0]    req,
	output logic [RS_IDX_W-1:0] grant_idx,
	output logic                grant_valid
);

	////////////////////////////////////////////////////////////
	// Priority encode
	////////////////////////////////////////////////////////////

	// Scan from the top so the lowest index is written last
	always_comb begin
		grant_idx = '0;
		for (int i = REQ_W - 1; i >= 0; i--) begin
			if (req[i]) begin
				grant_idx = RS_IDX_W'(i);
			end
		end
	end

	assign grant_valid = |req;

endmodule

//--- rs_tb.sv
// Testbench for rs_top: APB and dispatch tasks, reference model, issue compare and summary

`timescale 1ns/1ps

module rs_tb import rs_pkg::*; ();

	logic                             clock;
	logic                             arst_n;
	logic                             psel;
	logic                             penable;
	logic                             pwrite;
	logic [3:0]                       paddr;
	logic [31:0]                      pwdata;
	logic [31:0]                      prdata;
	logic                             pready;
	logic                             pslverr;
	logic [DISPATCH_W-1:0]            disp_valid;
	opcode_e [DISPATCH_W-1:0]         disp_opcode;
	logic [DISPATCH_W-1:0][TAG_W-1:0] disp_src1_tag;
	logic [DISPATCH_W-1:0]            disp_src1_ready;
	logic [DISPATCH_W-1:0][TAG_W-1:0] disp_src2_tag;
	logic [DISPATCH_W-1:0]            disp_src2_ready;
	logic [DISPATCH_W-1:0][TAG_W-1:0] disp_dest_tag;
	logic [DISPATCH_W-1:0]            disp_accept;
	logic [CDB_W-1:0]                 cdb_valid;
	logic [CDB_W-1:0][TAG_W-1:0]      cdb_tag;
	logic [NUM_FU-1:0]                issue_valid;
	opcode_e [NUM_FU-1:0]             issue_opcode;
	logic [NUM_FU-1:0][TAG_W-1:0]     issue_dest_tag;
	logic [NUM_FU-1:0][TAG_W-1:0]     issue_src1_tag;
	logic [NUM_FU-1:0][TAG_W-1:0]     issue_src2_tag;
	logic [NUM_FU-1:0]                issue_stall;

	// One dispatched instruction as the model sees it
	typedef struct packed {
		opcode_e          op;
		logic [TAG_W-1:0] src1;
		logic             src1_rdy;
		logic [TAG_W-1:0] src2;
		logic             src2_rdy;
		logic [TAG_W-1:0] dest;
		logic             issued;
	} instr_t;

	instr_t                   model_q[$];
	logic [(1<<TAG_W)-1:0]    bcast;
	logic [TAG_W-1:0]         next_dest;
	int seed = 68;
	int wait_limit = 200;
	int errors;
	int errors_at_start;
	int tests_run;
	int tests_passed;
	int issued_since_clear;

	rs_top dut (.*);

	always #20 clock = ~clock;

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Port from the opcode class; eligible once both sources are ready
	function automatic logic expected_issue(input instr_t rec, output fu_class_e port,
		output opcode_e op, output logic [TAG_W-1:0] src1, output logic [TAG_W-1:0] src2);
		port = opcode_class(rec.op);
		op = rec.op;
		src1 = rec.src1;
		src2 = rec.src2;
		return (rec.src1_rdy || bcast[rec.src1]) && (rec.src2_rdy || bcast[rec.src2]);
	endfunction

	function automatic int pending();
		int n;
		n = 0;
		foreach (model_q[i]) begin
			if (!model_q[i].issued) begin
				n++;
			end
		end
		return n;
	endfunction

	// Outputs settle well before the falling edge
	always @(negedge clock) begin : compare
		int idx;
		fu_class_e port;
		opcode_e op;
		logic [TAG_W-1:0] s1;
		logic [TAG_W-1:0] s2;
		logic elig;
		instr_t rec;
		if (arst_n) begin
			for (int c = 0; c < CDB_W; c++) begin
				if (cdb_valid[c]) begin
					bcast[cdb_tag[c]] = 1'b1;
				end
			end
			for (int p = 0; p < NUM_FU; p++) begin
				if (issue_valid[p]) begin
					idx = -1;
					for (int i = 0; i < model_q.size(); i++) begin
						if (!model_q[i].issued && model_q[i].dest == issue_dest_tag[p]) begin
							idx = i;
						end
					end
					if (idx < 0) begin
						$display("Error %0t ns: port %0d issued unknown dest tag %0d",
							$time, p, issue_dest_tag[p]);
						errors++;
					end else begin
						elig = expected_issue(model_q[idx], port, op, s1, s2);
						if (int'(port) != p || op != issue_opcode[p] ||
							s1 != issue_src1_tag[p] || s2 != issue_src2_tag[p]) begin
							$display("Error %0t ns: port %0d dest %0d has wrong fields",
								$time, p, issue_dest_tag[p]);
							errors++;
						end
						if (!elig) begin
							$display("Error %0t ns: dest %0d issued with a source not ready",
								$time, issue_dest_tag[p]);
							errors++;
						end
						model_q[idx].issued = 1'b1;
						issued_since_clear++;
					end
				end
			end
			// Records join after the issue check and issue next cycle at the earliest
			for (int k = 0; k < DISPATCH_W; k++) begin
				if (disp_valid[k] && disp_accept[k]) begin
					rec.op = disp_opcode[k];
					rec.src1 = disp_src1_tag[k];
					rec.src1_rdy = disp_src1_ready[k];
					rec.src2 = disp_src2_tag[k];
					rec.src2_rdy = disp_src2_ready[k];
					rec.dest = disp_dest_tag[k];
					rec.issued = 1'b0;
					model_q.push_back(rec);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Bus and dispatch tasks
	////////////////////////////////////////////////////////////

	task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
		output logic [31:0] rdata, output logic err);
		int t;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = data;
		@(posedge clock);
		#2;
		penable = 1'b1;
		t = 0;
		@(negedge clock);
		while (!pready && t < wait_limit) begin
			@(negedge clock);
			t++;
		end
		if (!pready) begin
			$display("Timeout: APB access to address %0h never saw pready", addr);
			errors++;
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clock);
		#2;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
		apb_access(1'b0, addr, 32'h0, data, err);
	endtask

	// cls picks the unit class or -1 for any
	task automatic fill_slot(input int k, input int cls, input logic rdy,
		input logic [TAG_W-1:0] wait_tag);
		int r;
		r = $random(seed);
		case (cls)
			0: disp_opcode[k] = opcode_e'({2'b00, r[1:0]});
			1: disp_opcode[k] = OP_MUL;
			2: disp_opcode[k] = r[0] ? OP_LOAD : OP_STORE;
			default: disp_opcode[k] = opcode_e'(r[3:0] % 4'd7);
		endcase
		disp_src1_tag[k] = rdy ? r[9:4] : wait_tag;
		disp_src1_ready[k] = rdy;
		disp_src2_tag[k] = r[15:10];
		disp_src2_ready[k] = 1'b1;
		disp_dest_tag[k] = next_dest;
		next_dest = next_dest + 1'b1;
		disp_valid[k] = 1'b1;
	endtask

	// Hold each slot until it is taken
	task automatic send_slots();
		logic [DISPATCH_W-1:0] taken;
		int t;
		t = 0;
		while (disp_valid != '0 && t < wait_limit) begin
			@(negedge clock);
			taken = disp_valid & disp_accept;
			@(posedge clock);
			#2;
			disp_valid = disp_valid & ~taken;
			t++;
		end
		if (disp_valid != '0) begin
			$display("Timeout: dispatch slots %b were never accepted", disp_valid);
			errors++;
			disp_valid = '0;
		end
	endtask

	task automatic dispatch_group(input int count, input int cls, input logic rdy,
		input int wait_base);
		for (int i = 0; i < count; i += 2) begin
			fill_slot(0, cls, rdy, TAG_W'(wait_base + i));
			if (i + 1 < count) begin
				fill_slot(1, cls, rdy, TAG_W'(wait_base + i + 1));
			end
			send_slots();
		end
	endtask

	task automatic broadcast(input logic [TAG_W-1:0] t0, input logic [TAG_W-1:0] t1);
		cdb_tag[0] = t0;
		cdb_tag[1] = t1;
		cdb_valid = '1;
		@(posedge clock);
		#2;
		cdb_valid = '0;
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		while (pending() != 0 && t < wait_limit) begin
			@(negedge clock);
			t++;
		end
		@(posedge clock);
		#2;
		if (pending() != 0) begin
			$display("Timeout: %0d instructions never issued", pending());
			errors++;
		end
	endtask

	task automatic begin_test();
		model_q.delete();
		bcast = '0;
		errors_at_start = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			tests_passed++;
			$display("Test %s: passed", name);
		end else begin
			$display("Test %s: failed with %0d errors", name, errors - errors_at_start);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin : stimulus
		logic err;
		logic [31:0] rd;
		clock = 1'b0;
		arst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		disp_valid = '0;
		disp_opcode[0] = OP_ADD;
		disp_opcode[1] = OP_ADD;
		disp_src1_tag = '0;
		disp_src1_ready = '0;
		disp_src2_tag = '0;
		disp_src2_ready = '0;
		disp_dest_tag = '0;
		cdb_valid = '0;
		cdb_tag = '0;
		issue_stall = '0;
		next_dest = '0;
		bcast = '0;
		errors = 0;
		tests_run = 0;
		tests_passed = 0;
		issued_since_clear = 0;
		repeat (4) @(posedge clock);
		#2;
		arst_n = 1'b1;

		// Still disabled after reset, so the first slot has to wait
		begin_test();
		fill_slot(0, -1, 1'b1, '0);
		@(negedge clock);
		if (disp_accept != '0) begin
			$display("Error %0t ns: disp_accept %b before enable", $time, disp_accept);
			errors++;
		end
		@(posedge clock);
		#2;
		apb_write(REG_CTRL, 32'h1, err);
		send_slots();
		dispatch_group(19, -1, 1'b1, 0);
		wait_drain();
		if (model_q.size() != 20) begin
			$display("Error %0t ns: %0d dispatches seen, expected 20", $time, model_q.size());
			errors++;
		end
		end_test("independent");

		// Sources wait on tags 40 and up
		begin_test();
		dispatch_group(8, -1, 1'b0, 40);
		repeat (5) @(posedge clock);
		#2;
		if (pending() != 8) begin
			$display("Error %0t ns: %0d of 8 waiting instructions issued early",
				$time, 8 - pending());
			errors++;
		end
		for (int j = 0; j < 8; j += 2) begin
			broadcast(TAG_W'(40 + j), TAG_W'(41 + j));
		end
		wait_drain();
		end_test("dependent");

		begin_test();
		issue_stall = 3'b010;
		dispatch_group(4, 1, 1'b1, 0);
		repeat (4) @(posedge clock);
		#2;
		apb_read(REG_STATUS, rd, err);
		if (rd[OCC_W-1:0] != 4'd4 || pending() != 4) begin
			$display("Error %0t ns: stalled MUL occupancy %0d, pending %0d, expected 4",
				$time, rd[OCC_W-1:0], pending());
			errors++;
		end
		issue_stall = '0;
		wait_drain();
		end_test("stall");

		begin_test();
		apb_write(REG_MASK, 32'h2, err);
		dispatch_group(RS_ENTRIES, 1, 1'b1, 0);
		repeat (3) @(posedge clock);
		@(negedge clock);
		if (disp_accept != '0) begin
			$display("Error %0t ns: disp_accept %b with a full table", $time, disp_accept);
			errors++;
		end
		@(posedge clock);
		#2;
		apb_read(REG_STATUS, rd, err);
		if (rd[OCC_W-1:0] != 4'd8 || pending() != RS_ENTRIES) begin
			$display("Error %0t ns: full table occupancy %0d, pending %0d, expected 8",
				$time, rd[OCC_W-1:0], pending());
			errors++;
		end
		apb_write(REG_MASK, 32'h0, err);
		wait_drain();
		apb_read(REG_STATUS, rd, err);
		if (rd[OCC_W-1:0] != 4'd0) begin
			$display("Error %0t ns: drained occupancy %0d, expected 0", $time, rd[OCC_W-1:0]);
			errors++;
		end
		end_test("mask and fill");

		// All ports held so the rows are still there at the flush
		begin_test();
		issue_stall = '1;
		dispatch_group(5, -1, 1'b1, 0);
		apb_read(REG_STATUS, rd, err);
		if (rd[OCC_W-1:0] != 4'd5) begin
			$display("Error %0t ns: occupancy %0d before flush, expected 5",
				$time, rd[OCC_W-1:0]);
			errors++;
		end
		apb_write(REG_CTRL, 32'h3, err);
		model_q.delete();
		apb_read(REG_STATUS, rd, err);
		if (rd[OCC_W-1:0] != 4'd0) begin
			$display("Error %0t ns: occupancy %0d after flush, expected 0",
				$time, rd[OCC_W-1:0]);
			errors++;
		end
		issue_stall = '0;
		repeat (6) @(posedge clock);
		#2;
		end_test("flush");

		begin_test();
		apb_write(REG_ISSUED, 32'h0, err);
		issued_since_clear = 0;
		dispatch_group(6, -1, 1'b1, 0);
		wait_drain();
		apb_read(REG_ISSUED, rd, err);
		if (rd[ISSUED_W-1:0] != issued_since_clear[ISSUED_W-1:0]) begin
			$display("Error %0t ns: issued counter %0d, expected %0d",
				$time, rd[ISSUED_W-1:0], issued_since_clear);
			errors++;
		end
		apb_read(4'h2, rd, err);
		if (err !== 1'b1) begin
			$display("Error %0t ns: no pslverr for unmapped address 0x2", $time);
			errors++;
		end
		end_test("counter and error");

		$display("Tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_passed, tests_run - tests_passed, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- rs_top.f
rs_pkg.sv
rs_wakeup_cam.sv
rs_select.sv
reservation_station.sv
rs_config_apb.sv
rs_top.sv
rs_checker.sv
rs_tb.sv

//--- rs_top.sv
// Top level joining the APB register block and the reservation station

`timescale 1ns/1ps

module rs_top import rs_pkg::*; (
	input  logic                                clock,
	input  logic                                arst_n,
	// APB
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [3:0]                          paddr,
	input  logic [31:0]                         pwdata,
	output logic [31:0]                         prdata,
	output logic                                pready,
	output logic                                pslverr,
	// Dispatch
	input  logic [DISPATCH_W-1:0]               disp_valid,
	input  opcode_e [DISPATCH_W-1:0]            disp_opcode,
	input  logic [DISPATCH_W-1:0][TAG_W-1:0]    disp_src1_tag,
	input  logic [DISPATCH_W-1:0]               disp_src1_ready,
	input  logic [DISPATCH_W-1:0][TAG_W-1:0]    disp_src2_tag,
	input  logic [DISPATCH_W-1:0]               disp_src2_ready,
	input  logic [DISPATCH_W-1:0][TAG_W-1:0]    disp_dest_tag,
	output logic [DISPATCH_W-1:0]               disp_accept,
	// Result bus
	input  logic [CDB_W-1:0]                    cdb_valid,
	input  logic [CDB_W-1:0][TAG_W-1:0]         cdb_tag,
	// Issue
	output logic [NUM_FU-1:0]                   issue_valid,
	output opcode_e [NUM_FU-1:0]                issue_opcode,
	output logic [NUM_FU-1:0][TAG_W-1:0]        issue_dest_tag,
	output logic [NUM_FU-1:0][TAG_W-1:0]        issue_src1_tag,
	output logic [NUM_FU-1:0][TAG_W-1:0]        issue_src2_tag,
	input  logic [NUM_FU-1:0]                   issue_stall
);

	// Control and status between the two blocks
	logic                   enable;
	logic                   flush;
	logic [NUM_FU-1:0]      fu_mask;
	logic [OCC_W-1:0]       occupancy;
	logic [ISSUE_CNT_W-1:0] issue_count;

	rs_config_apb u_config (
		.clock      (clock),
		.arst_n     (arst_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.occupancy  (occupancy),
		.issue_count(issue_count),
		.enable     (enable),
		.flush      (flush),
		.fu_mask    (fu_mask)
	);

	reservation_station u_station (
		.clock          (clock),
		.arst_n         (arst_n),
		.enable         (enable),
		.flush          (flush),
		.fu_mask        (fu_mask),
		.disp_valid     (disp_valid),
		.disp_opcode    (disp_opcode),
		.disp_src1_tag  (disp_src1_tag),
		.disp_src1_ready(disp_src1_ready),
		.disp_src2_tag  (disp_src2_tag),
		.disp_src2_ready(disp_src2_ready),
		.disp_dest_tag  (disp_dest_tag),
		.disp_accept    (disp_accept),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag),
		.issue_valid    (issue_valid),
		.issue_opcode   (issue_opcode),
		.issue_dest_tag (issue_dest_tag),
		.issue_src1_tag (issue_src1_tag),
		.issue_src2_tag (issue_src2_tag),
		.issue_stall    (issue_stall),
		.occupancy      (occupancy),
		.issue_count    (issue_count)
	);

endmodule

//--- rs_wakeup_cam.sv
// Tag-match array between stored source tags and the result-bus broadcast tags

`timescale 1ns/1ps

module rs_wakeup_cam import rs_pkg::*; (
	input  logic [RS_ENTRIES-1:0][1:0][TAG_W-1:0] entry_src_tags,
	input  logic [CDB_W-1:0]                      cdb_valid,
	input  logic [CDB_W-1:0][TAG_W-1:0]           cdb_tag,
	output logic [RS_ENTRIES-1:0][1:0]            src_hit
);

	////////////////////////////////////////////////////////////
	// Match every source against every valid lane
	////////////////////////////////////////////////////////////

	// Per-lane match bits before the OR
	logic [RS_ENTRIES-1:0][1:0][CDB_W-1:0] lane_hit;

	always_comb begin
		for (int r = 0; r < RS_ENTRIES; r++) begin
			for (int s = 0; s < 2; s++) begin
				for (int c = 0; c < CDB_W; c++) begin
					lane_hit[r][s][c] = cdb_valid[c] &&
						(entry_src_tags[r][s] == cdb_tag[c]);
				end
			end
		end
	end

	// Any lane wakes the source
	always_comb begin
		for (int r = 0; r < RS_ENTRIES; r++) begin
			for (int s = 0; s < 2; s++) begin
				src_hit[r][s] = |lane_hit[r][s];
			end
		end
	end

	// Busy and stored ready bits are combined by the station

endmodule
